//--- bench/issue_stage_vectors.svh
// rows hold the op count, ops oldest first as op rs rt rd, then valid and
// group position expected in lane0 and in lane1 for the group's first offer.

// alu opcodes outside the named compare and test codes.
localparam opcode_t op_add  = 6'b000001;
localparam opcode_t op_addi = 6'b010001;

typedef struct packed {
  opcode_t  op;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
} vec_op_t;

typedef struct packed {
  logic [2:0]    count;
  vec_op_t [0:3] ops;
  logic          lane0_vld;
  logic [1:0]    lane0_pos;
  logic          lane1_vld;
  logic [1:0]    lane1_pos;
} vec_row_t;

localparam vec_op_t pad = '{op_nop, 5'd0, 5'd0, 5'd0};

localparam int row_count = 10;

localparam vec_row_t vectors [row_count] = '{
  '{3'd2, '{'{op_add, 5'd2, 5'd3, 5'd1}, '{op_add, 5'd4, 5'd5, 5'd6}, pad, pad},
    1'b1, 2'd0, 1'b1, 2'd1},                                 // independent pair.
  '{3'd2, '{'{op_add, 5'd2, 5'd3, 5'd1}, '{op_add, 5'd1, 5'd4, 5'd5}, pad, pad},
    1'b1, 2'd0, 1'b0, 2'd0},                                 // raw.
  '{3'd2, '{'{op_addi, 5'd2, 5'd7, 5'd0}, '{op_add, 5'd3, 5'd4, 5'd7}, pad, pad},
    1'b1, 2'd0, 1'b0, 2'd0},                                 // waw.
  '{3'd2, '{'{op_add, 5'd1, 5'd2, 5'd3}, '{op_addi, 5'd4, 5'd1, 5'd0}, pad, pad},
    1'b1, 2'd0, 1'b0, 2'd0},                                 // war.
  '{3'd3, '{'{op_lw, 5'd2, 5'd8, 5'd0}, '{op_sw, 5'd3, 5'd9, 5'd0},
            '{op_add, 5'd10, 5'd11, 5'd12}, pad},
    1'b1, 2'd0, 1'b1, 2'd2},                                 // load skips the store.
  '{3'd2, '{'{op_add, 5'd1, 5'd2, 5'd3}, '{op_lw, 5'd4, 5'd5, 5'd0}, pad, pad},
    1'b1, 2'd1, 1'b1, 2'd0},                                 // younger load swaps.
  '{3'd2, '{'{op_cmp, 5'd1, 5'd2, 5'd3}, '{op_add, 5'd4, 5'd5, 5'd6}, pad, pad},
    1'b1, 2'd1, 1'b1, 2'd0},
  '{3'd2, '{'{op_add, 5'd1, 5'd2, 5'd3}, '{op_cmpi, 5'd4, 5'd9, 5'd0}, pad, pad},
    1'b1, 2'd0, 1'b1, 2'd1},
  '{3'd3, '{'{op_jmp, 5'd0, 5'd0, 5'd0}, '{op_testi, 5'd1, 5'd2, 5'd0},
            '{op_add, 5'd5, 5'd6, 5'd7}, pad},
    1'b1, 2'd2, 1'b1, 2'd0},                                 // second branch waits.
  '{3'd2, '{'{op_cmp, 5'd1, 5'd2, 5'd3}, '{op_testi, 5'd4, 5'd5, 5'd0}, pad, pad},
    1'b0, 2'd0, 1'b1, 2'd0}                                  // lone branch in lane1.
};

// opcodes drawn for the random fill runs.
localparam opcode_t op_mix [10] = '{
  op_nop, op_add, op_addi, op_cmp, op_test,
  op_cmpi, op_testi, op_lw, op_sw, op_jmp
};

//--- bench/issue_stage_tb.sv
`timescale 1ns/10ps

module issue_stage_tb import isa_pkg::*, issue_pkg::*;;

  `include "issue_stage_vectors.svh"

  localparam int queue_depth    = 8;
  localparam int cnt_w          = $clog2(queue_depth + 1);
  localparam int cycles_per_row = 80;
  localparam int margin         = 4;
  localparam int watchdog_ns    = (row_count + 6) * cycles_per_row * margin * 20;

  logic             clk;
  logic             rst_n;
  logic             push_req;
  entry_t           push_data;
  logic             push_ack;
  logic             issue_req;
  logic             issue_ack;
  slot_t            lane0;
  slot_t            lane1;
  logic [cnt_w-1:0] free;

  int unsigned     rand_seed = 32'h0dde4080;
  int unsigned     dummy;
  int              mismatches = 0;
  int              checks = 0;
  int              row_idx = 0;
  bit              row_pending = 1'b0;
  bit              req_seen = 1'b0;
  bit              ack_seen = 1'b0;
  vec_row_t        cur_row;
  logic [id_w-1:0] next_id = '0;
  logic [id_w-1:0] group_ids [4];
  entry_t          pending;
  entry_t          model_q [$];
  int              picked_ids [$];
  slot_t           exp0;
  slot_t           exp1;
  slot_t           snap0;
  slot_t           snap1;

  issue_stage #(.queue_depth(queue_depth)) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_req  (push_req),
    .push_data (push_data),
    .push_ack  (push_ack),
    .issue_req (issue_req),
    .issue_ack (issue_ack),
    .lane0     (lane0),
    .lane1     (lane1),
    .free      (free)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // reference rules for the queue model.

  function automatic reg_use_t regs_of(instr_u ins);
    reg_use_t u;
    u = '0;
    case (ins.r.opcode[5:4])
      2'b00: begin
        if (ins.r.opcode != op_nop) begin
          u = '{1'b1, ins.r.rs, 1'b1, ins.r.rt, 1'b1, ins.r.rd};
        end
      end
      2'b01: u = '{1'b1, ins.i.rs, 1'b0, 5'd0, 1'b1, ins.i.rt};
      2'b10: begin
        if (ins.i.opcode == op_lw) begin
          u = '{1'b1, ins.i.rs, 1'b0, 5'd0, 1'b1, ins.i.rt};
        end else if (ins.i.opcode == op_sw) begin
          u = '{1'b1, ins.i.rs, 1'b1, ins.i.rt, 1'b0, 5'd0};
        end
      end
      default: u = '0;  // jumps.
    endcase
    return u;
  endfunction

  function automatic pipe_t class_of(instr_u ins);
    opcode_t op;
    op = ins.r.opcode;
    if (op[5:4] == 2'b10) begin
      return pipe_mem;
    end
    if (op[5:4] == 2'b11 || op == op_cmp || op == op_test || op == op_cmpi ||
        op == op_testi) begin
      return pipe_branch;
    end
    return pipe_alu;
  endfunction

  // true when the older entry holds the younger one back.
  function automatic bit blocks(entry_t older, entry_t younger);
    reg_use_t o;
    reg_use_t y;
    o = regs_of(older.instr);
    y = regs_of(younger.instr);
    if (o.dest_en && ((y.src0_en && y.src0 == o.dest) || (y.src1_en && y.src1 == o.dest))) begin
      return 1'b1;
    end
    if (y.dest_en && ((o.src0_en && o.src0 == y.dest) || (o.src1_en && o.src1 == y.dest) ||
                      (o.dest_en && o.dest == y.dest))) begin
      return 1'b1;
    end
    return class_of(older.instr) == pipe_mem && class_of(younger.instr) == pipe_mem;
  endfunction

  function automatic bit may_pair(entry_t first, entry_t other);
    return !(class_of(first.instr) != pipe_alu &&
             class_of(first.instr) == class_of(other.instr));
  endfunction

  task automatic predict_lanes(output slot_t e0, output slot_t e1);
    int first;
    int second;
    bit ok;
    bit swap;
    slot_t s0;
    slot_t s1;
    first = -1;
    second = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      ok = 1'b1;
      for (int j = 0; j < i; j++) begin
        if (blocks(model_q[j], model_q[i])) begin
          ok = 1'b0;
        end
      end
      if (ok && first < 0) begin
        first = i;
      end else if (ok && second < 0 && may_pair(model_q[first], model_q[i])) begin
        second = i;
      end
    end
    s0 = '0;
    s1 = '0;
    picked_ids.delete();
    if (first >= 0) begin
      s0 = {1'b1, model_q[first]};
      picked_ids.push_back(model_q[first].id);
    end
    if (second >= 0) begin
      s1 = {1'b1, model_q[second]};
      picked_ids.push_back(model_q[second].id);
    end
    swap = (first >= 0 && class_of(model_q[first].instr) == pipe_branch) ||
           (second >= 0 && class_of(model_q[second].instr) == pipe_mem);
    e0 = swap ? s1 : s0;
    e1 = swap ? s0 : s1;
  endtask

  task automatic drop_offered();
    foreach (picked_ids[k]) begin
      for (int i = 0; i < model_q.size(); i++) begin
        if (model_q[i].id == picked_ids[k]) begin
          model_q.delete(i);
          break;
        end
      end
    end
    picked_ids.delete();
  endtask

  task automatic check_lane(input string name, input slot_t got, input slot_t exp);
    check_equal({name, " valid"}, got.valid, exp.valid);
    if (exp.valid) begin
      check_equal({name, " entry"}, got.entry, exp.entry);
    end
  endtask

  task automatic check_row_offer();
    string tag;
    tag = $sformatf("row %0d", row_idx);
    row_pending = 1'b0;
    check_equal({tag, " lane0 valid"}, lane0.valid, cur_row.lane0_vld);
    if (cur_row.lane0_vld) begin
      check_equal({tag, " lane0 id"}, lane0.entry.id, group_ids[cur_row.lane0_pos]);
    end
    check_equal({tag, " lane1 valid"}, lane1.valid, cur_row.lane1_vld);
    if (cur_row.lane1_vld) begin
      check_equal({tag, " lane1 id"}, lane1.entry.id, group_ids[cur_row.lane1_pos]);
    end
  endtask

  ////////////////////////////////////////
  // port monitor on settled outputs.

  always @(negedge clk) begin
    if (rst_n) begin
      if (issue_req && !req_seen) begin
        predict_lanes(exp0, exp1);  // queue as it was before this edge's push.
        check_lane("lane0", lane0, exp0);
        check_lane("lane1", lane1, exp1);
        if (row_pending) begin
          check_row_offer();
        end
        snap0 = lane0;
        snap1 = lane1;
      end else if (issue_req) begin
        check_equal("lane0 held", lane0, snap0);
        check_equal("lane1 held", lane1, snap1);
      end
      if (!issue_req && req_seen) begin
        drop_offered();
      end
      if (push_ack && !ack_seen) begin
        model_q.push_back(pending);
      end
      req_seen = issue_req;
      ack_seen = push_ack;
    end
  end

  ////////////////////////////////////////
  // drivers on the falling edge.

  function automatic entry_t make_entry(vec_op_t v);
    entry_t e;
    e = '0;
    if (v.op[5:4] == grp_reg) begin
      e.instr.r = '{v.op, v.rs, v.rt, v.rd, 11'($urandom)};
    end else begin
      e.instr.i = '{v.op, v.rs, v.rt, 16'($urandom)};
    end
    e.pc = addr_w'($urandom);
    e.id = next_id;
    next_id = next_id + 1'b1;
    return e;
  endfunction

  function automatic entry_t random_entry();
    vec_op_t v;
    v.op = op_mix[$urandom % 10];
    v.rs = reg_idx_t'($urandom % 8);  // few registers give many hazards.
    v.rt = reg_idx_t'($urandom % 8);
    v.rd = reg_idx_t'($urandom % 8);
    return make_entry(v);
  endfunction

  task automatic start_push(input entry_t e);
    pending = e;
    push_data = e;
    push_req = 1'b1;
  endtask

  task automatic finish_push();
    @(negedge clk);
    while (!push_ack) begin
      @(negedge clk);
    end
    push_req = 1'b0;
    @(negedge clk);
    while (push_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic push_entry(input entry_t e);
    start_push(e);
    finish_push();
  endtask

  task automatic ack_offer();
    while (!issue_req) begin
      @(negedge clk);
    end
    issue_ack = 1'b1;
    @(negedge clk);
    while (issue_req) begin
      @(negedge clk);
    end
    issue_ack = 1'b0;
    @(negedge clk);
  endtask

  task automatic drain_queue();
    while (model_q.size() != 0) begin
      ack_offer();
    end
    check_equal("free after drain", free, queue_depth);
  endtask

  // a lone nop takes the first offer so the group is picked together.
  task automatic run_row(input vec_row_t row);
    entry_t e;
    push_entry(make_entry(pad));
    for (int k = 0; k < row.count; k++) begin
      e = make_entry(row.ops[k]);
      group_ids[k] = e.id;
      push_entry(e);
    end
    cur_row = row;
    row_pending = 1'b1;
    drain_queue();
  endtask

  task automatic run_backpressure();
    for (int k = 0; k < queue_depth; k++) begin
      push_entry(random_entry());
    end
    check_equal("free when full", free, 0);
    start_push(random_entry());
    repeat (12) begin
      @(negedge clk);
      check_equal("push_ack while full", push_ack, 1'b0);
    end
    fork
      finish_push();
      ack_offer();
    join
    drain_queue();
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns, a handshake never completed", watchdog_ns);
    $display("errors: %0d mismatches in %0d checks", mismatches, checks);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    push_req  = 1'b0;
    push_data = '0;
    issue_ack = 1'b0;
    dummy     = $urandom(rand_seed);
    repeat (8) @(negedge clk);
    check_equal("push_ack in reset", push_ack, 1'b0);
    check_equal("issue_req in reset", issue_req, 1'b0);
    check_equal("lane0 valid in reset", lane0.valid, 1'b0);
    check_equal("lane1 valid in reset", lane1.valid, 1'b0);
    check_equal("free in reset", free, queue_depth);
    rst_n = 1'b1;
    for (int r = 0; r < row_count; r++) begin
      row_idx = r;
      run_row(vectors[r]);
    end
    repeat (3) run_backpressure();
    @(negedge clk);
    $display("errors: %0d mismatches in %0d checks", mismatches, checks);
    if (mismatches == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- issue_stage.f
+incdir+bench
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/op_decode.sv
rtl/issue_queue.sv
rtl/occupancy_counter.sv
rtl/offer_ctrl.sv
rtl/issue_picker.sv
rtl/issue_stage.sv
bench/issue_stage_tb.sv

//--- rtl/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////
  // instruction word.

  localparam int inst_w = 32;

  typedef logic [5:0] opcode_t;
  typedef logic [4:0] reg_idx_t;

  typedef struct packed {
    opcode_t               opcode;
    reg_idx_t              rs;
    reg_idx_t              rt;
    reg_idx_t              rd;
    logic [inst_w-22:0]    funct;  // 11 bits.
  } r_format_t;

  typedef struct packed {
    opcode_t               opcode;
    reg_idx_t              rs;
    reg_idx_t              rt;
    logic [inst_w-17:0]    imm;    // 16 bits.
  } i_format_t;

  typedef union packed {
    r_format_t r;
    i_format_t i;
  } instr_u;

  ////////////////////////////////////////
  // opcodes, top two bits give the group.

  localparam opcode_t op_nop   = 6'b000000;
  localparam opcode_t op_cmp   = 6'b000100;
  localparam opcode_t op_test  = 6'b000101;
  localparam opcode_t op_cmpi  = 6'b010100;
  localparam opcode_t op_testi = 6'b010101;
  localparam opcode_t op_lw    = 6'b100000;
  localparam opcode_t op_sw    = 6'b100001;
  localparam opcode_t op_jmp   = 6'b110000;

  localparam logic [1:0] grp_reg = 2'b00;
  localparam logic [1:0] grp_imm = 2'b01;
  localparam logic [1:0] grp_mem = 2'b10;
  localparam logic [1:0] grp_ctl = 2'b11;

  typedef enum logic [1:0] {
    pipe_alu    = 2'b00,
    pipe_mem    = 2'b01,
    pipe_branch = 2'b10
  } pipe_t;

endpackage

//--- rtl/issue_picker.sv
`timescale 1ns/10ps

module issue_picker import isa_pkg::*, issue_pkg::*; #(
  parameter int queue_depth = 8,
  localparam int idx_w = $clog2(queue_depth)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  entry_t                 entries [queue_depth],
  input  logic [queue_depth-1:0] valid,
  input  logic                   latch_pick,
  output logic [idx_w:0]         pick0,
  output logic [idx_w:0]         pick1,
  output slot_t                  lane0,
  output slot_t                  lane1,
  output pick_cnt_t              removed
);

  reg_use_t               reg_use [queue_depth];
  pipe_t                  pipe [queue_depth];
  logic [queue_depth-1:0] hazard;
  logic [queue_depth-1:0] eligible;
  logic [queue_depth-1:0] pairable;
  logic                   first_vld;
  logic                   second_vld;
  logic [idx_w-1:0]       first_idx;
  logic [idx_w-1:0]       second_idx;
  logic                   swap;
  slot_t                  slot0;
  slot_t                  slot1;

  // raw, war and waw between an older and a younger entry.
  function automatic logic reg_clash(reg_use_t older, reg_use_t younger);
    logic raw;
    logic war;
    logic waw;
    raw = older.dest_en &&
          ((younger.src0_en && (younger.src0 == older.dest)) ||
           (younger.src1_en && (younger.src1 == older.dest)));
    war = younger.dest_en &&
          ((older.src0_en && (older.src0 == younger.dest)) ||
           (older.src1_en && (older.src1 == younger.dest)));
    waw = younger.dest_en && older.dest_en && (younger.dest == older.dest);
    return raw || war || waw;
  endfunction

  for (genvar i = 0; i < queue_depth; i++) begin : g_decode
    op_decode u_decode (
      .instr   (entries[i].instr),
      .reg_use (reg_use[i]),
      .pipe    (pipe[i])
    );
  end

  ////////////////////////////////////////
  // split hazard against older entries.

  always_comb begin
    hazard = '0;
    for (int i = 1; i < queue_depth; i++) begin
      for (int j = 0; j < i; j++) begin
        if (valid[j] && (reg_clash(reg_use[j], reg_use[i]) ||
                         ((pipe[i] == pipe_mem) && (pipe[j] == pipe_mem)))) begin
          hazard[i] = 1'b1;
        end
      end
    end
  end

  assign eligible = valid & ~hazard;

  ////////////////////////////////////////
  // oldest-first pick.

  always_comb begin
    first_vld = 1'b0;
    first_idx = '0;
    for (int i = queue_depth - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        first_vld = 1'b1;
        first_idx = idx_w'(i);
      end
    end
  end

  // mem and branch pipes take one entry each.
  always_comb begin
    second_vld = 1'b0;
    second_idx = '0;
    for (int i = 0; i < queue_depth; i++) begin
      pairable[i] = eligible[i] && (idx_w'(i) != first_idx) &&
                    !((pipe[first_idx] != pipe_alu) && (pipe[i] == pipe[first_idx]));
    end
    for (int i = queue_depth - 1; i >= 0; i--) begin
      if (pairable[i]) begin
        second_vld = 1'b1;
        second_idx = idx_w'(i);
      end
    end
  end

  ////////////////////////////////////////
  // lane steering.

  assign swap = (first_vld && (pipe[first_idx] == pipe_branch)) ||
                (second_vld && (pipe[second_idx] == pipe_mem));

  always_comb begin
    slot0.valid = first_vld;
    slot0.entry = first_vld ? entries[first_idx] : '0;
    slot1.valid = second_vld;
    slot1.entry = second_vld ? entries[second_idx] : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane0.valid <= 1'b0;
      lane1.valid <= 1'b0;
      pick0       <= '0;
      pick1       <= '0;
      removed     <= '0;
    end else if (latch_pick) begin
      lane0   <= swap ? slot1 : slot0;
      lane1   <= swap ? slot0 : slot1;
      pick0   <= {first_vld, first_idx};
      pick1   <= {second_vld, second_idx};
      removed <= pick_cnt_t'(first_vld) + pick_cnt_t'(second_vld);
    end
  end

endmodule

//--- rtl/issue_pkg.sv
package issue_pkg;

  ////////////////////////////////////////
  // queue payload.

  localparam int addr_w = 16;
  localparam int id_w   = 6;

  typedef struct packed {
    isa_pkg::instr_u   instr;
    logic [addr_w-1:0] pc;
    logic [id_w-1:0]   id;
  } entry_t;

  typedef struct packed {
    logic   valid;
    entry_t entry;
  } slot_t;

  ////////////////////////////////////////
  // register use of one instruction.

  typedef struct packed {
    logic              src0_en;
    isa_pkg::reg_idx_t src0;
    logic              src1_en;
    isa_pkg::reg_idx_t src1;
    logic              dest_en;
    isa_pkg::reg_idx_t dest;
  } reg_use_t;

  // number of entries leaving per offer, 0 to 2.
  typedef logic [1:0] pick_cnt_t;

endpackage

//--- rtl/issue_queue.sv
`timescale 1ns/10ps

module issue_queue import issue_pkg::*; #(
  parameter int queue_depth = 8,
  localparam int idx_w = $clog2(queue_depth)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_req,
  input  entry_t                 push_data,
  output logic                   push_ack,
  input  logic                   full,
  input  logic                   remove,
  input  logic [idx_w:0]         pick0,
  input  logic [idx_w:0]         pick1,
  output entry_t                 entries [queue_depth],
  output logic [queue_depth-1:0] valid
);

  logic [queue_depth-1:0] drop;
  logic [queue_depth-1:0] keep;
  logic [queue_depth-1:0] packed_valid;
  entry_t                 packed_entries [queue_depth];
  logic [idx_w:0]         tail;
  logic                   push_fire;

  assign push_fire = push_req && !push_ack && !full;

  ////////////////////////////////////////
  // removal and compaction.

  always_comb begin
    for (int i = 0; i < queue_depth; i++) begin
      drop[i] = (pick0[idx_w] && (pick0[idx_w-1:0] == idx_w'(i))) ||
                (pick1[idx_w] && (pick1[idx_w-1:0] == idx_w'(i)));
    end
    keep = remove ? (valid & ~drop) : valid;
  end

  // survivors slide down, oldest stays at 0.
  always_comb begin
    tail         = '0;
    packed_valid = '0;
    for (int i = 0; i < queue_depth; i++) begin
      packed_entries[i] = entries[i];
    end
    for (int i = 0; i < queue_depth; i++) begin
      if (keep[i]) begin
        packed_entries[tail[idx_w-1:0]] = entries[i];
        packed_valid[tail[idx_w-1:0]]   = 1'b1;
        tail                            = tail + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // state.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid    <= '0;
      push_ack <= 1'b0;
    end else begin
      valid <= packed_valid;
      if (push_fire) begin
        valid[tail[idx_w-1:0]] <= 1'b1;  // append behind the survivors.
        push_ack               <= 1'b1;
      end else if (!push_req) begin
        push_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    entries <= packed_entries;
    if (push_fire) begin
      entries[tail[idx_w-1:0]] <= push_data;
    end
  end

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/10ps

module issue_stage import issue_pkg::*; #(
  parameter int queue_depth = 8,
  localparam int idx_w = $clog2(queue_depth),
  localparam int cnt_w = $clog2(queue_depth + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_req,
  input  entry_t           push_data,
  output logic             push_ack,
  output logic             issue_req,
  input  logic             issue_ack,
  output slot_t            lane0,
  output slot_t            lane1,
  output logic [cnt_w-1:0] free
);

  entry_t                 entries [queue_depth];
  logic [queue_depth-1:0] valid;
  logic                   full;
  logic                   empty;
  logic                   push_done;
  logic                   latch_pick;
  logic                   remove;
  logic [idx_w:0]         pick0;
  logic [idx_w:0]         pick1;
  pick_cnt_t              removed;
  pick_cnt_t              removed_now;

  assign push_done   = push_req && !push_ack && !full;  // same term the queue appends on.
  assign empty       = (free == cnt_w'(queue_depth));
  assign removed_now = remove ? removed : '0;

  issue_queue #(.queue_depth(queue_depth)) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_req  (push_req),
    .push_data (push_data),
    .push_ack  (push_ack),
    .full      (full),
    .remove    (remove),
    .pick0     (pick0),
    .pick1     (pick1),
    .entries   (entries),
    .valid     (valid)
  );

  occupancy_counter #(.queue_depth(queue_depth)) u_count (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_done (push_done),
    .removed   (removed_now),
    .full      (full),
    .free      (free)
  );

  offer_ctrl u_offer (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .issue_ack  (issue_ack),
    .latch_pick (latch_pick),
    .remove     (remove),
    .issue_req  (issue_req)
  );

  issue_picker #(.queue_depth(queue_depth)) u_picker (
    .clk        (clk),
    .rst_n      (rst_n),
    .entries    (entries),
    .valid      (valid),
    .latch_pick (latch_pick),
    .pick0      (pick0),
    .pick1      (pick1),
    .lane0      (lane0),
    .lane1      (lane1),
    .removed    (removed)
  );

endmodule

//--- rtl/occupancy_counter.sv
`timescale 1ns/10ps

module occupancy_counter import issue_pkg::*; #(
  parameter int queue_depth = 8,
  localparam int cnt_w = $clog2(queue_depth + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_done,
  input  pick_cnt_t        removed,
  output logic             full,
  output logic [cnt_w-1:0] free
);

  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;

  // push and removal may land on the same edge.
  assign count_next = count + cnt_w'(push_done) - cnt_w'(removed);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      full  <= 1'b0;
      free  <= cnt_w'(queue_depth);
    end else begin
      count <= count_next;
      full  <= (count_next == cnt_w'(queue_depth));
      free  <= cnt_w'(queue_depth) - count_next;
    end
  end

endmodule

//--- rtl/offer_ctrl.sv
`timescale 1ns/10ps

module offer_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic empty,
  input  logic issue_ack,
  output logic latch_pick,
  output logic remove,
  output logic issue_req
);

  typedef enum logic [1:0] {
    st_idle,
    st_offer,
    st_release
  } state_t;

  state_t state;

  assign latch_pick = (state == st_idle) && !empty;
  assign remove     = (state == st_offer) && issue_ack;  // one cycle, state moves on.

  ////////////////////////////////////////
  // four-phase offer.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      issue_req <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (latch_pick) begin
            state     <= st_offer;
            issue_req <= 1'b1;
          end
        end
        st_offer: begin
          if (issue_ack) begin
            state     <= st_release;
            issue_req <= 1'b0;
          end
        end
        st_release: begin
          if (!issue_ack) begin
            state <= st_idle;  // pipes dropped ack.
          end
        end
        default: begin
          state     <= st_idle;
          issue_req <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/op_decode.sv
`timescale 1ns/10ps

module op_decode import isa_pkg::*, issue_pkg::*; (
  input  instr_u   instr,
  output reg_use_t reg_use,
  output pipe_t    pipe
);

  opcode_t op;

  assign op = instr.r.opcode;

  always_comb begin
    reg_use = '0;
    case (op[5:4])
      grp_reg: begin
        if (op != op_nop) begin
          reg_use.src0_en = 1'b1;
          reg_use.src0    = instr.r.rs;
          reg_use.src1_en = 1'b1;
          reg_use.src1    = instr.r.rt;
          reg_use.dest_en = 1'b1;
          reg_use.dest    = instr.r.rd;
        end
      end
      grp_imm: begin
        reg_use.src0_en = 1'b1;
        reg_use.src0    = instr.i.rs;
        reg_use.dest_en = 1'b1;
        reg_use.dest    = instr.i.rt;
      end
      grp_mem: begin
        reg_use.src0_en = (op == op_lw) || (op == op_sw);  // base address.
        reg_use.src0    = instr.i.rs;
        reg_use.src1_en = (op == op_sw);                   // store data.
        reg_use.src1    = instr.i.rt;
        reg_use.dest_en = (op == op_lw);
        reg_use.dest    = instr.i.rt;
      end
      default: begin
        reg_use = '0;  // jumps read nothing here.
      end
    endcase
  end

  always_comb begin
    if (op[5:4] == grp_mem) begin
      pipe = pipe_mem;
    end else if ((op[5:4] == grp_ctl) || (op == op_cmp) || (op == op_test) ||
                 (op == op_cmpi) || (op == op_testi)) begin
      pipe = pipe_branch;
    end else begin
      pipe = pipe_alu;
    end
  end

endmodule
